//--- tests/display_golden.txt
// word 0: reset count, then per reset the sout word and the expected serialized_conf
// next: sample count, then per sample column byte, bit byte, expected 30-bit lane word
0000000000000003
00009c3f0a571e82
00009c3f0a571e82
0000a5a55a5a0ff0
0000a5a55a5a0ff0
0000123456789abc
0000123456789abc
000000000000000c
0000_00_00_08040201
0000_00_01_04020100
0000_00_05_00402010
0000_00_2f_02010080
0000_01_00_04020100
0000_02_0a_01008040
0000_03_14_00402010
0000_04_21_04020100
0000_05_28_08040201
0000_06_2e_20100804
0000_07_0d_02010080
0000_07_2f_08040201

//--- sim.f
logic/pixel_pkg.sv
logic/driver_pkg.sv
logic/framebuffer_emulator.sv
logic/driver_controller.sv
logic/column_mux.sv
logic/display_top.sv
tests/display_checker.sv
tests/display_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the display testbench, exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module display_tb -f sim.f -Mdir obj_dir &&
    ./obj_dir/Vdisplay_tb ||
    { echo "simulation did not pass"; exit 1; }

//--- tests/display_tb.sv
`timescale 1ns/1ps

module display_tb
    import pixel_pkg::*, driver_pkg::*;
();

    localparam int pattern_mode = 9;
    localparam int blanking_time = 72;
    localparam int num_check_columns = 10;
    localparam int drive_delay = 5;
    localparam int timeout_cycles = 400;

    logic        clock_33;
    logic        nrst;
    logic        sout;
    logic        sclk;
    logic        gclk;
    logic        lat;
    lane_word_t  sin;
    conf_word_t  serialized_conf;
    logic        new_configuration_ready;
    column_sel_t mux_out;

    // golden entries, layout described at the top of the file
    logic [63:0] golden [0:63];
    int          num_resets;
    int          num_samples;
    int          sample_base;
    int          golden_hits;

    display_top #(
        .pattern_mode (pattern_mode),
        .blanking_time(blanking_time)
    ) i_dut (
        .clock_33               (clock_33),
        .nrst                   (nrst),
        .sout                   (sout),
        .sclk                   (sclk),
        .gclk                   (gclk),
        .lat                    (lat),
        .sin                    (sin),
        .serialized_conf        (serialized_conf),
        .new_configuration_ready(new_configuration_ready),
        .mux_out                (mux_out)
    );

    initial clock_33 = 1'b0;
    always #50 clock_33 = ~clock_33;

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_lane(input string name, input lane_word_t expected,
                              input lane_word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_conf(input string name, input conf_word_t expected,
                              input conf_word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_column(input string name, input column_sel_t expected,
                                input column_sel_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAIL %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAIL %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // samples and drives sit a few ns past the rising edge
    task automatic step();
        @(posedge clock_33);
        #drive_delay;
    endtask

    task automatic wait_sclk_rise(input string where);
        logic prev;
        logic found;
        prev  = sclk;
        found = 1'b0;
        for (int n = 0; n < timeout_cycles && !found; n++) begin
            step();
            found = !prev && sclk;
            prev  = sclk;
        end
        if (!found) begin
            stop_with_failure($sformatf("timed out waiting for sclk to rise during %s", where));
        end
    endtask

    task automatic wait_sclk_low(input string where);
        logic found;
        found = 1'b0;
        for (int n = 0; n < timeout_cycles && !found; n++) begin
            step();
            found = !sclk;
        end
        if (!found) begin
            stop_with_failure($sformatf("timed out waiting for sclk to go low during %s", where));
        end
    endtask

    // expected lane word from the pattern rule
    // lit lanes repeat every pattern_mode lanes
    function automatic lane_word_t pattern_at(input int b, input int c);
        lane_word_t word;
        int         first;
        word  = '0;
        first = (pattern_mode - ((b + c) % pattern_mode)) % pattern_mode;
        for (int l = first; l < num_lanes; l += pattern_mode) begin
            word[l] = 1'b1;
        end
        return word;
    endfunction

    task automatic apply_reset();
        nrst = 1'b0;
        sout = 1'b0;
        repeat (16) step();
        check_bit("reset sclk", 1'b0, sclk);
        check_bit("reset gclk", 1'b0, gclk);
        check_bit("reset lat", 1'b0, lat);
        check_bit("reset new_configuration_ready", 1'b0, new_configuration_ready);
        check_lane("reset sin", '0, sin);
        check_conf("reset serialized_conf", '0, serialized_conf);
        check_column("reset mux_out", '0, mux_out);
        nrst = 1'b1;
    endtask

    // the other idle outputs hold zero until sclk first rises
    task automatic wait_first_sclk();
        logic found;
        found = 1'b0;
        for (int n = 0; n < timeout_cycles && !found; n++) begin
            step();
            found = sclk;
            if (!found) begin
                check_bit("idle gclk", 1'b0, gclk);
                check_bit("idle lat", 1'b0, lat);
                check_bit("idle new_configuration_ready", 1'b0, new_configuration_ready);
                check_column("idle mux_out", '0, mux_out);
            end
        end
        if (!found) begin
            stop_with_failure("sclk never started after reset");
        end
    endtask

    task automatic run_conf_write();
        wait_first_sclk();
        for (int i = 0; i < shift_len; i++) begin
            if (i > 0) begin
                wait_sclk_rise("configuration write");
            end
            check_lane($sformatf("conf bit %0d sin", i),
                       {num_lanes{conf_default[shift_len-1-i]}}, sin);
            check_bit($sformatf("conf bit %0d lat", i), i >= shift_len - lat_conf_bits, lat);
        end
    endtask

    task automatic run_readback(input conf_word_t word, input conf_word_t expected, input int r);
        logic found;
        for (int i = 0; i < shift_len; i++) begin
            wait_sclk_low("readback");
            sout = word[shift_len-1-i];
            wait_sclk_rise("readback");
        end
        found = new_configuration_ready;
        for (int n = 0; n < timeout_cycles && !found; n++) begin
            step();
            found = new_configuration_ready;
        end
        if (!found) begin
            stop_with_failure("new_configuration_ready never pulsed after readback");
        end
        check_conf($sformatf("readback %0d serialized_conf", r), expected, serialized_conf);
        step();
        check_bit("new_configuration_ready width", 1'b0, new_configuration_ready);
        sout = 1'b0;
    endtask

    task automatic match_golden(input int c, input int b);
        logic [63:0] entry;
        for (int s = 0; s < num_samples; s++) begin
            entry = golden[sample_base + s];
            if (int'(entry[47:40]) == c && int'(entry[39:32]) == b) begin
                check_lane($sformatf("golden column %0d bit %0d", c, b), entry[29:0], sin);
                golden_hits++;
            end
        end
    endtask

    task automatic run_columns();
        int          c;
        int          low;
        logic        found;
        for (int k = 0; k < num_check_columns; k++) begin
            c = k % num_columns;
            for (int b = 0; b < shift_len; b++) begin
                wait_sclk_rise("column shift");
                check_lane($sformatf("column %0d bit %0d sin", k, b), pattern_at(b, c), sin);
                check_bit($sformatf("column %0d bit %0d lat", k, b), b == shift_len - 1, lat);
                if (k < num_columns) begin
                    match_golden(c, b);
                end
            end
            // gclk stays low through blanking, then restarts with the new column
            low   = 0;
            found = 1'b0;
            for (int n = 0; n < timeout_cycles && !found; n++) begin
                step();
                if (gclk) begin
                    found = 1'b1;
                end else begin
                    low++;
                end
            end
            if (!found) begin
                stop_with_failure("gclk never restarted after blanking");
            end
            if (low != blanking_time) begin
                stop_with_failure($sformatf("FAIL column %0d blanking expected %0d actual %0d",
                                            k, blanking_time, low));
            end
            check_column($sformatf("column %0d mux_out", k), column_sel_t'(1) << c, mux_out);
        end
    endtask

    initial begin
        nrst        = 1'b0;
        sout        = 1'b0;
        golden_hits = 0;
        $readmemh("tests/display_golden.txt", golden);
        num_resets  = int'(golden[0]);
        if (num_resets < 1 || num_resets > 8) begin
            stop_with_failure("golden file holds no usable reset count");
        end
        num_samples = int'(golden[1 + 2 * num_resets]);
        sample_base = 2 + 2 * num_resets;
        if (num_samples < 1 || sample_base + num_samples > 64) begin
            stop_with_failure("golden file holds no usable sample count");
        end

        for (int r = 0; r < num_resets; r++) begin
            apply_reset();
            run_conf_write();
            run_readback(golden[1 + 2 * r][47:0], golden[2 + 2 * r][47:0], r);
        end
        run_columns();

        if (golden_hits != num_samples) begin
            stop_with_failure("not every golden sample was reached in the column loop");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- tests/display_checker.sv
`timescale 1ns/1ps

module display_checker (
    input logic clock_33,
    input logic nrst,
    input logic sclk,
    input logic gclk,
    input logic lat,
    input logic blanking,
    input logic driver_ready,
    input logic column_ready,
    input logic new_configuration_ready
);

    // set once the readback word has been reported
    logic conf_seen;

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            conf_seen <= 1'b0;
        end else if (new_configuration_ready) begin
            conf_seen <= 1'b1;
        end
    end

    lat_with_sclk_low: assert property (@(posedge clock_33) disable iff (!nrst)
        (lat != $past(lat)) |-> !sclk)
        else $error("lat changed while sclk was high");

    gclk_low_in_blanking: assert property (@(posedge clock_33) disable iff (!nrst)
        blanking |-> !gclk)
        else $error("gclk ran during blanking");

    driver_ready_single: assert property (@(posedge clock_33) disable iff (!nrst)
        driver_ready |=> !driver_ready)
        else $error("driver_ready held longer than one cycle");

    column_ready_single: assert property (@(posedge clock_33) disable iff (!nrst)
        column_ready |=> !column_ready)
        else $error("column_ready held longer than one cycle");

    conf_ready_once: assert property (@(posedge clock_33) disable iff (!nrst)
        new_configuration_ready |-> !conf_seen)
        else $error("new_configuration_ready pulsed twice after one reset");

endmodule

bind driver_controller display_checker i_checker (
    .clock_33               (clock_33),
    .nrst                   (nrst),
    .sclk                   (sclk),
    .gclk                   (gclk),
    .lat                    (lat),
    .blanking               (state == st_blank),
    .driver_ready           (driver_ready),
    .column_ready           (column_ready),
    .new_configuration_ready(new_configuration_ready)
);

//--- logic/display_top.sv
`timescale 1ns/1ps

module display_top
    import pixel_pkg::*, driver_pkg::*;
#(
    parameter int pattern_mode  = 9,
    parameter int blanking_time = 72
) (
    input  logic        clock_33,
    input  logic        nrst,
    input  logic        sout,
    output logic        sclk,
    output logic        gclk,
    output logic        lat,
    output lane_word_t  sin,
    output conf_word_t  serialized_conf,
    output logic        new_configuration_ready,
    output column_sel_t mux_out
);

    lane_word_t framebuffer_data;
    logic       driver_ready;
    logic       column_ready;

    // test pattern source in place of the real framebuffer
    framebuffer_emulator #(
        .pattern_mode(pattern_mode)
    ) main_fb_emulator (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .driver_ready(driver_ready),
        .data        (framebuffer_data)
    );

    driver_controller #(
        .blanking_time(blanking_time)
    ) main_driver_controller (
        .clock_33               (clock_33),
        .nrst                   (nrst),
        .data                   (framebuffer_data),
        .sout                   (sout),
        .sclk                   (sclk),
        .gclk                   (gclk),
        .lat                    (lat),
        .sin                    (sin),
        .driver_ready           (driver_ready),
        .column_ready           (column_ready),
        .serialized_conf        (serialized_conf),
        .new_configuration_ready(new_configuration_ready)
    );

    column_mux main_column_mux (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .column_ready(column_ready),
        .mux_out     (mux_out)
    );

endmodule

//--- logic/column_mux.sv
`timescale 1ns/1ps

module column_mux
    import pixel_pkg::*;
(
    input  logic        clock_33,
    input  logic        nrst,
    input  logic        column_ready,
    output column_sel_t mux_out
);

    column_sel_t next_sel;

    // first column enters at bit 0, later ones rotate left
    always_comb begin
        if (mux_out == '0) begin
            next_sel = column_sel_t'(1);
        end else begin
            next_sel = {mux_out[num_columns-2:0], mux_out[num_columns-1]};
        end
    end

    // no column driven until the first data has been latched
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            mux_out <= '0;
        end else if (column_ready) begin
            mux_out <= next_sel;
        end
    end

endmodule

//--- logic/driver_controller.sv
`timescale 1ns/1ps

module driver_controller
    import pixel_pkg::*, driver_pkg::*;
#(
    parameter int blanking_time = 72
) (
    input  logic       clock_33,
    input  logic       nrst,
    input  lane_word_t data,
    input  logic       sout,
    output logic       sclk,
    output logic       gclk,
    output logic       lat,
    output lane_word_t sin,
    output logic       driver_ready,
    output logic       column_ready,
    output conf_word_t serialized_conf,
    output logic       new_configuration_ready
);

    localparam int bit_w   = $clog2(shift_len);
    localparam int blank_w = $clog2(blanking_time + 1);
    localparam logic [bit_w-1:0] last_bit       = bit_w'(shift_len - 1);
    localparam logic [bit_w-1:0] lat_conf_start = bit_w'(shift_len - lat_conf_bits);
    localparam logic [bit_w-1:0] lat_data_start = bit_w'(shift_len - lat_data_bits);
    localparam logic [blank_w-1:0] last_blank   = blank_w'(blanking_time - 1);

    typedef enum logic [2:0] {
        st_start,
        st_conf,
        st_read,
        st_data,
        st_blank
    } state_t;

    state_t           state;
    state_t           next_state;
    logic [bit_w-1:0] bit_cnt;
    logic [bit_w-1:0] next_bit;
    logic [blank_w-1:0] blank_cnt;
    logic             load;
    lane_word_t       load_sin;
    logic             load_lat;
    logic [shift_len-2:0] rd_shift;

    // load marks the edge that opens the sclk low half of a new bit
    always_comb begin
        next_state = state;
        next_bit   = bit_cnt;
        load       = 1'b0;
        case (state)
            st_start: begin
                next_state = st_conf;
                load       = 1'b1;
            end
            st_conf, st_read, st_data: begin
                if (sclk) begin
                    load = 1'b1;
                    if (bit_cnt == last_bit) begin
                        next_bit = '0;
                        case (state)
                            st_conf: next_state = st_read;
                            st_read: next_state = st_data;
                            default: begin
                                next_state = st_blank;
                                load       = 1'b0;
                            end
                        endcase
                    end else begin
                        next_bit = bit_cnt + 1'b1;
                    end
                end
            end
            st_blank: begin
                if (blank_cnt == last_blank) begin
                    next_state = st_data;
                    load       = 1'b1;
                end
            end
            default: next_state = st_start;
        endcase
    end

    // lane word and latch level for the bit about to go out
    // readback shifts zeros, so it keeps the defaults
    always_comb begin
        load_sin = '0;
        load_lat = 1'b0;
        case (next_state)
            st_conf: begin
                load_sin = {num_lanes{conf_default[shift_len - 1 - int'(next_bit)]}};
                load_lat = next_bit >= lat_conf_start;
            end
            st_data: begin
                load_sin = data;
                load_lat = next_bit >= lat_data_start;
            end
            default: ;
        endcase
    end

    // emulator steps once sin holds its word
    assign driver_ready = (state == st_data) && !sclk;
    assign column_ready = (state == st_blank) && (blank_cnt == last_blank);

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            state                   <= st_start;
            bit_cnt                 <= '0;
            blank_cnt               <= '0;
            sclk                    <= 1'b0;
            gclk                    <= 1'b0;
            lat                     <= 1'b0;
            sin                     <= '0;
            serialized_conf         <= '0;
            new_configuration_ready <= 1'b0;
        end else begin
            state   <= next_state;
            bit_cnt <= next_bit;
            if (state == st_blank && next_state == st_blank) begin
                blank_cnt <= blank_cnt + 1'b1;
            end else begin
                blank_cnt <= '0;
            end

            // gclk only runs in the column loop and starts high on bit 0,
            // so it is already low on the latch bit's high half
            gclk <= (next_state == st_data) ? ~gclk : 1'b0;

            if (load) begin
                sin  <= load_sin;
                lat  <= load_lat;
                sclk <= 1'b0;
            end else if (next_state == st_blank) begin
                sin  <= '0;
                lat  <= 1'b0;
                sclk <= 1'b0;
            end else begin
                sclk <= 1'b1;
            end

            new_configuration_ready <= 1'b0;
            if (state == st_read && !sclk && bit_cnt == last_bit) begin
                serialized_conf         <= {rd_shift, sout};
                new_configuration_ready <= 1'b1;
            end
        end
    end

    // sout sampled on the edge that raises sclk, MSB first
    always_ff @(posedge clock_33) begin
        if (state == st_read && !sclk) begin
            rd_shift <= {rd_shift[shift_len-3:0], sout};
        end
    end

endmodule

//--- logic/framebuffer_emulator.sv
`timescale 1ns/1ps

module framebuffer_emulator
    import pixel_pkg::*, driver_pkg::*;
#(
    parameter int pattern_mode = 9
) (
    input  logic       clock_33,
    input  logic       nrst,
    input  logic       driver_ready,
    output lane_word_t data
);

    localparam int bit_w = $clog2(shift_len);
    localparam int col_w = $clog2(num_columns);
    localparam logic [bit_w-1:0] last_bit = bit_w'(shift_len - 1);
    localparam logic [col_w-1:0] last_col = col_w'(num_columns - 1);

    logic [bit_w-1:0] bit_cnt;
    logic [bit_w-1:0] next_bit;
    logic [col_w-1:0] col_cnt;
    logic [col_w-1:0] next_col;

    // lane l is lit when (b + c + l) mod pattern_mode is zero
    function automatic lane_word_t pattern_word(input int b, input int c);
        lane_word_t word;
        for (int l = 0; l < num_lanes; l++) begin
            word[l] = ((b + c + l) % pattern_mode) == 0;
        end
        return word;
    endfunction

    // position of the word that follows the one now on data
    always_comb begin
        next_bit = bit_cnt + 1'b1;
        next_col = col_cnt;
        if (bit_cnt == last_bit) begin
            next_bit = '0;
            if (col_cnt == last_col) begin
                next_col = '0;
            end else begin
                next_col = col_cnt + 1'b1;
            end
        end
    end

    // bit 0 of column 0 sits on data straight out of reset
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            bit_cnt <= '0;
            col_cnt <= '0;
            data    <= pattern_word(0, 0);
        end else if (driver_ready) begin
            bit_cnt <= next_bit;
            col_cnt <= next_col;
            data    <= pattern_word(int'(next_bit), int'(next_col));
        end
    end

endmodule

//--- logic/driver_pkg.sv
package driver_pkg;

    // bits in each driver shift register
    localparam int shift_len = 48;

    // one configuration word as the driver holds it
    typedef logic [shift_len-1:0] conf_word_t;

    // written to every lane after reset, MSB first
    localparam conf_word_t conf_default = 48'h9C3F_0A57_1E82;

    // latch held high over the final bits of a configuration write
    localparam int lat_conf_bits = 5;

    // latch held high over the final bit of a data shift
    localparam int lat_data_bits = 1;

endpackage

//--- logic/pixel_pkg.sv
package pixel_pkg;

    // serial data lanes into the driver chain, one bit each per sclk
    localparam int num_lanes = 30;

    // one bit for every lane, presented together on sin
    typedef logic [num_lanes-1:0] lane_word_t;

    // columns behind the multiplexer
    localparam int num_columns = 8;

    // one-hot column select, all zero while no column is driven
    typedef logic [num_columns-1:0] column_sel_t;

endpackage
